//--- design/stream_pkg.sv
// ******************************
// stream package
// shared widths, beat struct and frame mux states
// ******************************

package stream_pkg;

    localparam int DATA_WIDTH = 8;
    localparam int NUM_PORTS  = 4;
    localparam int SEL_WIDTH  = 2;
    localparam int FIFO_DEPTH = 4;

    // lane fifo pointer and occupancy widths
    localparam int PTR_WIDTH  = $clog2(FIFO_DEPTH);
    localparam int CNT_WIDTH  = $clog2(FIFO_DEPTH + 1);

    // one beat of a stream with valid and ready beside it
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
        logic                  user;
    } axis_beat_t;

    typedef enum logic {
        MUX_IDLE,
        MUX_FRAME
    } mux_state_t;

endpackage

//--- design/lane_fifo.sv
// ******************************
// lane fifo
// small circular buffer of beats with a registered head output
// ******************************

`timescale 1ns/1ps

module lane_fifo
    import stream_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    axis_beat_t           mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] mem_count;
    logic [CNT_WIDTH-1:0] occupancy;
    logic                 push;
    logic                 load;

    function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // the output register counts toward the lane capacity
    assign occupancy = mem_count + CNT_WIDTH'(out_valid);
    assign in_ready  = occupancy < CNT_WIDTH'(FIFO_DEPTH);
    assign push      = in_valid & in_ready;

    // refill head register when it is empty or draining this cycle
    assign load = (mem_count != '0) & (~out_valid | out_ready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            mem_count <= '0;
            out_valid <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (load)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({push, load})
                2'b10:   mem_count <= mem_count + 1'b1;
                2'b01:   mem_count <= mem_count - 1'b1;
                default: mem_count <= mem_count;
            endcase
            if (load)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;
        end
    end

    // storage and head payload
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_beat;
        if (load)
            out_beat <= mem[rd_ptr];
    end

endmodule

//--- design/frame_mux.sv
// ******************************
// frame mux
// four to one stream mux, select latched per frame,
// registered lane ready and a two-register output stage
// ******************************

`timescale 1ns/1ps

module frame_mux
    import stream_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  axis_beat_t           lane_beat [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] lane_valid,
    output logic [NUM_PORTS-1:0] lane_ready,
    input  logic [SEL_WIDTH-1:0] select,
    output axis_beat_t           out_beat,
    output logic                 out_valid,
    input  logic                 out_ready
);

    mux_state_t           state;
    mux_state_t           state_next;
    logic [SEL_WIDTH-1:0] sel_reg;
    logic [SEL_WIDTH-1:0] sel_next;
    logic [NUM_PORTS-1:0] ready_next;

    // currently latched lane
    axis_beat_t           cur_beat;
    logic                 cur_valid;
    logic                 cur_ready;
    logic                 lane_fire;

    // output stage
    axis_beat_t           skid_beat;
    logic                 skid_valid;
    logic                 ready_int;
    logic                 ready_early;

    assign cur_beat  = lane_beat[sel_reg];
    assign cur_valid = lane_valid[sel_reg];
    assign cur_ready = lane_ready[sel_reg];
    assign lane_fire = cur_valid & cur_ready & (state == MUX_FRAME);

    // room for one more beat next cycle even if the output stalls
    // when the output drains, when both registers are empty
    // or when the skid is empty and no beat arrives this cycle
    assign ready_early = out_ready
                       | (~skid_valid & ~out_valid)
                       | (~skid_valid & ~lane_fire);

    always_comb begin
        state_next = state;
        sel_next   = sel_reg;
        ready_next = '0;

        case (state)
            MUX_IDLE: begin
                // a frame starts and takes the select value now
                if (lane_valid[select]) begin
                    state_next = MUX_FRAME;
                    sel_next   = select;
                end
            end
            MUX_FRAME: begin
                if (lane_fire && cur_beat.last)
                    state_next = MUX_IDLE;
            end
        endcase

        // only the chosen lane sees ready and only inside a frame
        if (state_next == MUX_FRAME)
            ready_next[sel_next] = ready_early;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= MUX_IDLE;
            sel_reg    <= '0;
            lane_ready <= '0;
            ready_int  <= 1'b0;
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            state      <= state_next;
            sel_reg    <= sel_next;
            lane_ready <= ready_next;
            ready_int  <= ready_early;

            if (ready_int) begin
                if (out_ready | ~out_valid)
                    out_valid <= lane_fire;
                else
                    skid_valid <= lane_fire;
            end else if (out_ready) begin
                // drain skid into the output register
                out_valid  <= skid_valid;
                skid_valid <= 1'b0;
            end
        end
    end

    // payload follows the same steering as the valid bits
    always_ff @(posedge clk) begin
        if (ready_int) begin
            if (out_ready | ~out_valid)
                out_beat <= cur_beat;
            else
                skid_beat <= cur_beat;
        end else if (out_ready) begin
            out_beat <= skid_beat;
        end
    end

endmodule

//--- design/stream_mux_top.sv
// ******************************
// stream mux top
// four input lanes drained by one frame mux
// ******************************

`timescale 1ns/1ps

module stream_mux_top
    import stream_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  axis_beat_t           in_beat [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] in_valid,
    output logic [NUM_PORTS-1:0] in_ready,
    input  logic [SEL_WIDTH-1:0] select,
    output axis_beat_t           out_beat,
    output logic                 out_valid,
    input  logic                 out_ready
);

    axis_beat_t           lane_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] lane_valid;
    logic [NUM_PORTS-1:0] lane_ready;

    // one fifo lane per external port
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_lane
        lane_fifo u_lane_fifo (
            .clk       (clk),
            .rst       (rst),
            .in_beat   (in_beat[i]),
            .in_valid  (in_valid[i]),
            .in_ready  (in_ready[i]),
            .out_beat  (lane_beat[i]),
            .out_valid (lane_valid[i]),
            .out_ready (lane_ready[i])
        );
    end

    frame_mux u_frame_mux (
        .clk        (clk),
        .rst        (rst),
        .lane_beat  (lane_beat),
        .lane_valid (lane_valid),
        .lane_ready (lane_ready),
        .select     (select),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

//--- verif/stream_mux_properties.sv
// ******************************
// stream mux properties
// handshake checks on the frame mux output and lane readies
// ******************************

`timescale 1ns/1ps

module stream_mux_properties
    import stream_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input axis_beat_t           out_beat,
    input logic                 out_valid,
    input logic                 out_ready,
    input logic [NUM_PORTS-1:0] lane_ready,
    input mux_state_t           state
);

    // a stalled output beat must not move or vanish
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("output beat changed while the output was stalled");

    a_ready_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(lane_ready))
        else $error("more than one lane ready is high");

    a_idle_no_ready: assert property (@(posedge clk) disable iff (rst)
        (state == MUX_IDLE) |-> (lane_ready == '0))
        else $error("lane ready is high while the mux is idle");

endmodule

bind frame_mux stream_mux_properties u_stream_mux_properties (
    .clk        (clk),
    .rst        (rst),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .lane_ready (lane_ready),
    .state      (state)
);

//--- verif/tb_stream_mux.sv
// ******************************
// stream mux testbench
// directed frames through the four lanes and the frame mux
// ******************************

`timescale 1ns/1ps

module tb_stream_mux
    import stream_pkg::*;
();

    localparam int SINGLE_LEN     = 5;
    localparam int HOLD_LEN       = 6;
    localparam int LONG_LEN       = 24;
    localparam int TURN_LEN       = 8;
    localparam int MAX_LEN        = 32;
    localparam int TOTAL_BEATS    = SINGLE_LEN + 2 * HOLD_LEN + LONG_LEN + NUM_PORTS * TURN_LEN;
    localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 8 + 200;

    logic                 clk;
    logic                 rst;
    axis_beat_t           in_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;
    logic [SEL_WIDTH-1:0] select;
    axis_beat_t           out_beat;
    logic                 out_valid;
    logic                 out_ready;

    // scoreboard in output order with the frames stored per port
    axis_beat_t expected [$];
    axis_beat_t exp_beat;
    axis_beat_t frame_mem [NUM_PORTS][MAX_LEN];
    int         frame_len [NUM_PORTS];
    int         accepted [NUM_PORTS];
    int         first_stall [NUM_PORTS];
    int         turn_order [NUM_PORTS] = '{3, 0, 2, 1};
    logic       frame_sent;
    int         out_count = 0;
    int         cycles = 0;
    int         seed = 20430;

    stream_mux_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .select    (select),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected_val,
                               input string what);
        if (actual !== expected_val) begin
            $display("** Error at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected_val);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // every output handshake takes the oldest expected beat
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (expected.size() == 0) begin
                $display("output beat at time %0t arrived with nothing expected", $time);
                $display("Simulation FAILED");
                $fatal(1, "unexpected output beat");
            end else begin
                exp_beat = expected.pop_front();
                check_value(32'(out_beat), 32'(exp_beat), "output beat");
                out_count = out_count + 1;
            end
        end
    end

    task automatic make_frame(input int port, input int len);
        axis_beat_t beat;
        for (int i = 0; i < len; i++) begin
            beat.data = DATA_WIDTH'($random(seed));
            beat.user = ($random(seed) % 2) != 0;
            beat.last = (i == len - 1);
            frame_mem[port][i] = beat;
            expected.push_back(beat);
        end
        frame_len[port] = len;
    endtask

    // starts and returns on a falling edge
    task automatic send_frame(input int port);
        for (int i = 0; i < frame_len[port]; i++) begin
            in_beat[port]  = frame_mem[port][i];
            in_valid[port] = 1'b1;
            while (!in_ready[port]) begin
                if (first_stall[port] < 0)
                    first_stall[port] = accepted[port];
                @(negedge clk);
            end
            @(negedge clk);
            accepted[port] = accepted[port] + 1;
        end
        in_valid[port] = 1'b0;
    endtask

    task automatic clear_counts();
        for (int p = 0; p < NUM_PORTS; p++) begin
            accepted[p]    = 0;
            first_stall[p] = -1;
        end
    endtask

    task automatic wait_out_count(input int target);
        while (out_count < target)
            @(negedge clk);
    endtask

    task automatic wait_drained();
        while (expected.size() != 0)
            @(negedge clk);
    endtask

    task automatic step_select(input int base);
        for (int k = 0; k < NUM_PORTS; k++) begin
            select = SEL_WIDTH'(turn_order[k]);
            // the mux has latched once the frame shows at the output
            wait_out_count(base + k * TURN_LEN + 1);
        end
    endtask

    task automatic check_reset_state();
        check_value(32'(out_valid), 32'(1'b0), "out_valid after reset");
        check_value(32'(in_ready), 32'({NUM_PORTS{1'b1}}), "in_ready after reset");
    endtask

    task automatic single_frame();
        select = SEL_WIDTH'(0);
        make_frame(0, SINGLE_LEN);
        send_frame(0);
        wait_drained();
    endtask

    task automatic select_held_mid_frame();
        int base;
        base   = out_count;
        select = SEL_WIDTH'(1);
        make_frame(1, HOLD_LEN);
        make_frame(2, HOLD_LEN);
        fork
            send_frame(1);
            send_frame(2);
            begin
                wait_out_count(base + 1);
                select = SEL_WIDTH'(2);
            end
        join
        wait_drained();
    endtask

    task automatic backpressure_long_frame();
        clear_counts();
        select     = SEL_WIDTH'(0);
        out_ready  = 1'b0;
        frame_sent = 1'b0;
        make_frame(0, LONG_LEN);
        fork
            begin
                send_frame(0);
                frame_sent = 1'b1;
            end
            begin
                // output held low until the lane pushes back
                while (first_stall[0] < 0)
                    @(negedge clk);
                check_value(32'(first_stall[0] <= FIFO_DEPTH + 3), 32'(1'b1),
                            "in_ready fell within FIFO_DEPTH + 3 beats");
                while (!frame_sent || expected.size() != 0) begin
                    @(negedge clk);
                    out_ready = ($random(seed) % 2) != 0;
                end
            end
        join
        out_ready = 1'b1;
    endtask

    task automatic all_ports_in_turn();
        clear_counts();
        select = SEL_WIDTH'(turn_order[0]);
        for (int k = 0; k < NUM_PORTS; k++)
            make_frame(turn_order[k], TURN_LEN);
        fork
            send_frame(0);
            send_frame(1);
            send_frame(2);
            send_frame(3);
            step_select(out_count);
        join
        wait_drained();
        // ports after the first wait with a full lane
        for (int k = 1; k < NUM_PORTS; k++)
            check_value(first_stall[turn_order[k]], FIFO_DEPTH, "beats taken by a waiting port");
    endtask

    initial begin
        rst        = 1'b1;
        in_valid   = '0;
        select     = '0;
        out_ready  = 1'b1;
        frame_sent = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++)
            in_beat[p] = '0;
        clear_counts();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        check_reset_state();
        single_frame();
        select_held_mid_frame();
        backpressure_long_frame();
        all_ports_in_turn();

        if (expected.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("%0d expected beats never reached the output", expected.size());
            $display("Simulation FAILED");
            $fatal(1, "scoreboard not empty");
        end
    end

endmodule

//--- all.f
design/stream_pkg.sv
design/lane_fifo.sv
design/frame_mux.sv
design/stream_mux_top.sv
verif/stream_mux_properties.sv
verif/tb_stream_mux.sv

//--- Makefile
# Verilator build and run of the stream mux testbench

VERILATOR ?= verilator
TOP       ?= tb_stream_mux
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Simulation PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
